// File: mcu_params.svh
/*
 * MCU always-on slice: widths and interrupt vector positions
 */

`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

// Interrupt vector as seen by the core
`define MCU_INTR_W 32

// Always-on GPIO interrupt lines
`define MCU_GPIO_AO_W 8

// Timer counter and compare width
`define MCU_TIMER_W 16

// Machine timer interrupt position
`define MCU_TIMER_IRQ_BIT 7

// Machine external interrupt position
`define MCU_EXT_IRQ_BIT 11

// First fast interrupt, GPIO line k sits at base + k
`define MCU_FAST_IRQ_BASE 16

`endif

// File: mcu_pkg.sv
/*
 * MCU always-on slice: shared vector types and power states
 */

`default_nettype none

`include "mcu_params.svh"

package mcu_pkg;

  // Interrupt vector and wake mask
  typedef logic [`MCU_INTR_W-1:0] intr_vec_t;

  // Always-on GPIO interrupt lines
  typedef logic [`MCU_GPIO_AO_W-1:0] gpio_ao_t;

  // Timer count and compare value
  typedef logic [`MCU_TIMER_W-1:0] timer_cnt_t;

  // CPU domain power sequence
  typedef enum logic [2:0] {
    PWR_ON,
    PWR_ISO,
    PWR_RST,
    PWR_SW_OFF,
    PWR_OFF,
    PWR_SW_ON,
    PWR_UNISO,
    PWR_UNRST
  } pwr_state_e;

endpackage

`default_nettype wire

// File: rv_timer_lite.sv
/*
 * Single channel compare-match timer
 * Raises a one-cycle interrupt pulse and restarts on every match
 */

`timescale 1ns/1ns
`default_nettype none

module rv_timer_lite (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  input  wire logic               timer_en_i,
  input  wire mcu_pkg::timer_cnt_t timer_cmp_i,
  output logic                    timer_intr_o
);

  import mcu_pkg::*;

  timer_cnt_t cnt_q;
  logic       match;

  assign match = (cnt_q == timer_cmp_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (!timer_en_i) begin
      cnt_q <= '0;
    end else if (match) begin
      // Automatic restart on compare match
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Pulse lands in the cycle after the match
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      timer_intr_o <= 1'b0;
    end else begin
      timer_intr_o <= timer_en_i & match;
    end
  end

endmodule

`default_nettype wire

// File: irq_collector.sv
/*
 * Interrupt collector: packs sources into the core vector, registers it
 * and derives the power manager wakeup request
 */

`timescale 1ns/1ns
`default_nettype none

`include "mcu_params.svh"

module irq_collector (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic              timer_intr_i,
  input  wire logic              ext_intr_i,
  input  wire mcu_pkg::gpio_ao_t  gpio_ao_intr_i,
  input  wire mcu_pkg::intr_vec_t wake_mask_i,
  output mcu_pkg::intr_vec_t     intr_o,
  output logic                   wakeup_o
);

  import mcu_pkg::*;

  intr_vec_t intr_d;
  intr_vec_t intr_q;
  intr_vec_t intr_masked;

  // Vector layout follows the core's machine interrupt map
  always_comb begin
    intr_d = '0;
    intr_d[`MCU_TIMER_IRQ_BIT] = timer_intr_i;
    intr_d[`MCU_EXT_IRQ_BIT] = ext_intr_i;
    // Always-on GPIO in the fast range
    intr_d[`MCU_FAST_IRQ_BASE +: `MCU_GPIO_AO_W] = gpio_ao_intr_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      intr_q <= '0;
    end else begin
      intr_q <= intr_d;
    end
  end

  assign intr_o = intr_q;

  // Only enabled sources may wake the CPU domain
  assign intr_masked = intr_q & wake_mask_i;
  assign wakeup_o = |intr_masked;

endmodule

`default_nettype wire

// File: pwr_manager_fsm.sv
/*
 * CPU domain power manager: isolates, resets and switches off the domain
 * when the core sleeps, and brings it back on an enabled interrupt
 */

`timescale 1ns/1ns
`default_nettype none

module pwr_manager_fsm (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  input  wire logic core_sleep_i,
  input  wire logic wakeup_i,
  input  wire logic debug_reset_ni,
  input  wire logic cpu_switch_ack_ni,
  output logic      cpu_switch_no,
  output logic      cpu_iso_no,
  output logic      cpu_rst_no
);

  import mcu_pkg::*;

  pwr_state_e state_q;
  pwr_state_e state_d;

  logic cpu_switch_n_d;
  logic cpu_switch_n_q;
  logic cpu_iso_n_d;
  logic cpu_iso_n_q;
  logic cpu_rst_n_d;
  logic cpu_rst_n_q;

  // Next state
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      PWR_ON: begin
        // A pending enabled interrupt keeps the domain up
        if (core_sleep_i && !wakeup_i) begin
          state_d = PWR_ISO;
        end
      end
      PWR_ISO: begin
        state_d = PWR_RST;
      end
      PWR_RST: begin
        state_d = PWR_SW_OFF;
      end
      PWR_SW_OFF: begin
        // Ack high means the switch has opened
        if (cpu_switch_ack_ni) begin
          state_d = PWR_OFF;
        end
      end
      PWR_OFF: begin
        if (wakeup_i) begin
          state_d = PWR_SW_ON;
        end
      end
      PWR_SW_ON: begin
        if (!cpu_switch_ack_ni) begin
          state_d = PWR_UNISO;
        end
      end
      PWR_UNISO: begin
        state_d = PWR_UNRST;
      end
      PWR_UNRST: begin
        state_d = PWR_ON;
      end
      default: begin
        state_d = PWR_ON;
      end
    endcase
  end

  // Output levels of the state being entered
  always_comb begin
    cpu_switch_n_d = 1'b0;
    cpu_iso_n_d = 1'b1;
    cpu_rst_n_d = 1'b1;
    unique case (state_d)
      PWR_ISO: begin
        cpu_iso_n_d = 1'b0;
      end
      PWR_RST: begin
        cpu_iso_n_d = 1'b0;
        cpu_rst_n_d = 1'b0;
      end
      PWR_SW_OFF, PWR_OFF: begin
        cpu_switch_n_d = 1'b1;
        cpu_iso_n_d = 1'b0;
        cpu_rst_n_d = 1'b0;
      end
      PWR_SW_ON: begin
        cpu_iso_n_d = 1'b0;
        cpu_rst_n_d = 1'b0;
      end
      PWR_UNISO: begin
        cpu_rst_n_d = 1'b0;
      end
      default: begin
        cpu_switch_n_d = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= PWR_ON;
      cpu_switch_n_q <= 1'b0;
      cpu_iso_n_q <= 1'b1;
      cpu_rst_n_q <= 1'b1;
    end else begin
      state_q <= state_d;
      cpu_switch_n_q <= cpu_switch_n_d;
      cpu_iso_n_q <= cpu_iso_n_d;
      cpu_rst_n_q <= cpu_rst_n_d;
    end
  end

  assign cpu_switch_no = cpu_switch_n_q;
  assign cpu_iso_no = cpu_iso_n_q;

  // Debug module can reset the core on its own
  assign cpu_rst_no = cpu_rst_n_q & debug_reset_ni;

endmodule

`default_nettype wire

// File: mini_mcu_top.sv
/*
 * Always-on power control slice of the MCU: timer, interrupt
 * collection and CPU domain power manager
 */

`timescale 1ns/1ns
`default_nettype none

module mini_mcu_top (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  input  wire logic               timer_en_i,
  input  wire mcu_pkg::timer_cnt_t timer_cmp_i,
  input  wire mcu_pkg::gpio_ao_t   gpio_ao_intr_i,
  input  wire logic               ext_intr_i,
  input  wire mcu_pkg::intr_vec_t  wake_mask_i,
  input  wire logic               core_sleep_i,
  input  wire logic               debug_reset_ni,
  input  wire logic               cpu_switch_ack_ni,
  output mcu_pkg::intr_vec_t      intr_o,
  output logic                    cpu_switch_no,
  output logic                    cpu_iso_no,
  output logic                    cpu_rst_no
);

  // Timer channel 0 pulse
  logic timer_intr;

  // Masked interrupt level towards the power manager
  logic wakeup;

  rv_timer_lite u_rv_timer_lite (
    .clk_i,
    .arst_n_i,
    .timer_en_i,
    .timer_cmp_i,
    .timer_intr_o(timer_intr)
  );

  irq_collector u_irq_collector (
    .clk_i,
    .arst_n_i,
    .timer_intr_i(timer_intr),
    .ext_intr_i,
    .gpio_ao_intr_i,
    .wake_mask_i,
    .intr_o,
    .wakeup_o(wakeup)
  );

  pwr_manager_fsm u_pwr_manager_fsm (
    .clk_i,
    .arst_n_i,
    .core_sleep_i,
    .wakeup_i(wakeup),
    .debug_reset_ni,
    .cpu_switch_ack_ni,
    .cpu_switch_no,
    .cpu_iso_no,
    .cpu_rst_no
  );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/*
 * Testbench clock source, 8 ns period
 */

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// File: mini_mcu_assert.sv
/*
 * Power sequencing assertions for the CPU domain power manager
 */

`timescale 1ns/1ns
`default_nettype none

module mini_mcu_assert (
  input wire logic clk_i,
  input wire logic arst_n_i,
  input wire logic cpu_switch_n_i,
  input wire logic cpu_iso_n_i,
  input wire logic cpu_rst_n_i,
  input wire logic cpu_switch_ack_n_i
);

  // Failure count for the end of run summary
  int unsigned fail_cnt = 0;

  // Isolation already active when the internal reset falls
  iso_before_rst: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(cpu_rst_n_i) |-> $past(!cpu_iso_n_i))
    else begin
      fail_cnt++;
      $error("internal CPU reset fell while isolation was inactive");
    end

  // Reset and isolation active a cycle before the switch opens
  sw_off_when_safe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cpu_switch_n_i |-> (!cpu_iso_n_i && !cpu_rst_n_i
                        && $past(!cpu_iso_n_i && !cpu_rst_n_i)))
    else begin
      fail_cnt++;
      $error("power switch open without reset and isolation active");
    end

  // Ack low means the domain has power again
  uniso_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(cpu_iso_n_i) |-> !cpu_switch_ack_n_i)
    else begin
      fail_cnt++;
      $error("isolation released before the switch acknowledged power on");
    end

endmodule

`default_nettype wire

// File: tb_mini_mcu.sv
/*
 * Testbench for the MCU always-on slice: table driven interrupt and
 * power sequencing checks, switch acknowledge model and timer checks
 */

`timescale 1ns/1ns
`default_nettype none

`include "mcu_params.svh"

module tb_mini_mcu;

  import mcu_pkg::*;

  localparam int NUM_ROWS = 13;
  localparam int ROW_TIMEOUT = 48;
  localparam int SETTLE_CYCLES = 8;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 64 + 200;
  localparam logic [1:0] KIND_HOLD = 2'd0;
  localparam logic [1:0] KIND_DOWN = 2'd1;
  localparam logic [1:0] KIND_UP = 2'd2;

  // exp_pwr is {switch_n, iso_n, rst_n}
  typedef struct packed {
    gpio_ao_t   gpio;
    logic       ext;
    intr_vec_t  mask;
    logic       sleep;
    intr_vec_t  exp_intr;
    logic [2:0] exp_pwr;
    logic [1:0] kind;
  } row_t;

  logic       clk;
  logic       arst_n;
  logic       timer_en;
  timer_cnt_t timer_cmp;
  gpio_ao_t   gpio_ao_intr;
  logic       ext_intr;
  intr_vec_t  wake_mask;
  logic       core_sleep;
  logic       debug_reset_n;
  logic       cpu_switch_ack_n;
  intr_vec_t  intr;
  logic       cpu_switch_n;
  logic       cpu_iso_n;
  logic       cpu_rst_n;

  row_t   rows [NUM_ROWS];
  int     err_cnt = 0;
  int     cyc = 0;
  integer seed = 15;

  // Cycle stamps of power output edges
  int   iso_fall_cyc = 0;
  int   iso_rise_cyc = 0;
  int   rst_fall_cyc = 0;
  int   rst_rise_cyc = 0;
  int   sw_rise_cyc = 0;
  int   sw_fall_cyc = 0;
  int   ack_fall_cyc = 0;
  logic iso_prev = 1'b1;
  logic rst_prev = 1'b1;
  logic sw_prev = 1'b0;
  logic ack_prev = 1'b0;

  tb_clk_gen u_tb_clk_gen (
    .clk_o(clk)
  );

  mini_mcu_top u_mini_mcu_top (
    .clk_i(clk),
    .arst_n_i(arst_n),
    .timer_en_i(timer_en),
    .timer_cmp_i(timer_cmp),
    .gpio_ao_intr_i(gpio_ao_intr),
    .ext_intr_i(ext_intr),
    .wake_mask_i(wake_mask),
    .core_sleep_i(core_sleep),
    .debug_reset_ni(debug_reset_n),
    .cpu_switch_ack_ni(cpu_switch_ack_n),
    .intr_o(intr),
    .cpu_switch_no(cpu_switch_n),
    .cpu_iso_no(cpu_iso_n),
    .cpu_rst_no(cpu_rst_n)
  );

  bind pwr_manager_fsm mini_mcu_assert u_mini_mcu_assert (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .cpu_switch_n_i(cpu_switch_no),
    .cpu_iso_n_i(cpu_iso_no),
    .cpu_rst_n_i(cpu_rst_n_q),
    .cpu_switch_ack_n_i(cpu_switch_ack_ni)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  always @(negedge clk) begin
    if (iso_prev && !cpu_iso_n) iso_fall_cyc <= cyc;
    if (!iso_prev && cpu_iso_n) iso_rise_cyc <= cyc;
    if (rst_prev && !cpu_rst_n) rst_fall_cyc <= cyc;
    if (!rst_prev && cpu_rst_n) rst_rise_cyc <= cyc;
    if (!sw_prev && cpu_switch_n) sw_rise_cyc <= cyc;
    if (sw_prev && !cpu_switch_n) sw_fall_cyc <= cyc;
    if (ack_prev && !cpu_switch_ack_n) ack_fall_cyc <= cyc;
    iso_prev <= cpu_iso_n;
    rst_prev <= cpu_rst_n;
    sw_prev <= cpu_switch_n;
    ack_prev <= cpu_switch_ack_n;
  end

  // Power switch answers 1 to 4 cycles after the request changes
  initial begin : ack_model
    int delay;
    cpu_switch_ack_n = 1'b0;
    forever begin
      @(posedge clk);
      if (cpu_switch_n !== cpu_switch_ack_n) begin
        delay = 1 + ({$random(seed)} % 4);
        repeat (delay - 1) @(posedge clk);
        cpu_switch_ack_n <= cpu_switch_n;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_cnt++;
      $display("ERROR at %0t ns: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
    end
  endtask

  task automatic check_power(input logic [2:0] exp_pwr);
    check_value("cpu_switch_no", cpu_switch_n, exp_pwr[2]);
    check_value("cpu_iso_no", cpu_iso_n, exp_pwr[1]);
    check_value("cpu_rst_no", cpu_rst_n, exp_pwr[0]);
  endtask

  task automatic load_table();
    rows[0] = {8'h00, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 3'b011, KIND_HOLD};
    rows[1] = {8'h01, 1'b0, 32'h0000_0000, 1'b0, 32'h0001_0000, 3'b011, KIND_HOLD};
    rows[2] = {8'h80, 1'b1, 32'h0000_0000, 1'b0, 32'h0080_0800, 3'b011, KIND_HOLD};
    rows[3] = {8'h5A, 1'b0, 32'h0000_0000, 1'b0, 32'h005A_0000, 3'b011, KIND_HOLD};
    rows[4] = {8'h00, 1'b1, 32'h0000_0000, 1'b0, 32'h0000_0800, 3'b011, KIND_HOLD};
    rows[5] = {8'h00, 1'b0, 32'h0000_0800, 1'b1, 32'h0000_0000, 3'b100, KIND_DOWN};
    // GPIO 2 is not in the wake mask
    rows[6] = {8'h04, 1'b0, 32'h0000_0800, 1'b1, 32'h0004_0000, 3'b100, KIND_HOLD};
    rows[7] = {8'h04, 1'b1, 32'h0000_0800, 1'b1, 32'h0004_0800, 3'b011, KIND_UP};
    rows[8] = {8'h10, 1'b1, 32'h0010_0800, 1'b1, 32'h0010_0800, 3'b011, KIND_HOLD};
    rows[9] = {8'h00, 1'b0, 32'h0010_0000, 1'b0, 32'h0000_0000, 3'b011, KIND_HOLD};
    rows[10] = {8'h00, 1'b0, 32'h0010_0000, 1'b1, 32'h0000_0000, 3'b100, KIND_DOWN};
    rows[11] = {8'h10, 1'b0, 32'h0010_0000, 1'b0, 32'h0010_0000, 3'b011, KIND_UP};
    rows[12] = {8'hFF, 1'b1, 32'h0000_0000, 1'b0, 32'h00FF_0800, 3'b011, KIND_HOLD};
  endtask

  task automatic apply_row(input int idx);
    row_t r;
    int   waited;
    r = rows[idx];
    @(posedge clk);
    gpio_ao_intr <= r.gpio;
    ext_intr <= r.ext;
    wake_mask <= r.mask;
    core_sleep <= r.sleep;
    @(posedge clk);
    @(negedge clk);
    check_value("intr_o", intr, r.exp_intr);
    waited = 0;
    while ({cpu_switch_n, cpu_iso_n, cpu_rst_n} !== r.exp_pwr && waited < ROW_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if ({cpu_switch_n, cpu_iso_n, cpu_rst_n} !== r.exp_pwr) begin
      err_cnt++;
      $display("Row %0d: power outputs did not settle within %0d cycles", idx, ROW_TIMEOUT);
    end
    repeat (SETTLE_CYCLES) @(negedge clk);
    check_value("intr_o", intr, r.exp_intr);
    check_power(r.exp_pwr);
    if (r.kind == KIND_DOWN) begin
      check_value("cpu_rst_no fall delay", rst_fall_cyc - iso_fall_cyc, 1);
      check_value("cpu_switch_no rise delay", sw_rise_cyc - rst_fall_cyc, 1);
      check_value("cpu_switch_ack_ni", cpu_switch_ack_n, 1'b1);
    end
    if (r.kind == KIND_UP) begin
      if (!(sw_fall_cyc < ack_fall_cyc && ack_fall_cyc < iso_rise_cyc)) begin
        err_cnt++;
        $display("Row %0d: isolation released out of order with the switch ack", idx);
      end
      check_value("cpu_rst_no rise delay", rst_rise_cyc - iso_rise_cyc, 1);
    end
  endtask

  task automatic run_timer(input int cmp);
    int        c;
    int        last;
    intr_vec_t exp;
    last = cmp + 2 + 3 * (cmp + 1);
    @(posedge clk);
    timer_cmp <= cmp[15:0];
    timer_en <= 1'b1;
    for (c = 1; c <= last; c++) begin
      @(posedge clk);
      @(negedge clk);
      exp = '0;
      if (c >= cmp + 2 && (c - cmp - 2) % (cmp + 1) == 0) exp[`MCU_TIMER_IRQ_BIT] = 1'b1;
      check_value("intr_o", intr, exp);
    end
    @(posedge clk);
    timer_en <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    int i;
    int assert_errs;
    timer_en = 1'b0;
    timer_cmp = '0;
    gpio_ao_intr = '0;
    ext_intr = 1'b0;
    wake_mask = '0;
    core_sleep = 1'b0;
    debug_reset_n = 1'b1;
    arst_n = 1'b0;
    load_table();
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("intr_o", intr, '0);
    check_power(3'b011);
    for (i = 0; i < NUM_ROWS; i++) begin
      apply_row(i);
    end
    // Debug reset with the domain on
    @(posedge clk);
    debug_reset_n <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_power(3'b010);
    end
    @(posedge clk);
    debug_reset_n <= 1'b1;
    @(negedge clk);
    check_power(3'b011);
    @(posedge clk);
    gpio_ao_intr <= '0;
    ext_intr <= 1'b0;
    wake_mask <= '0;
    repeat (3) @(posedge clk);
    run_timer(5);
    run_timer(2);
    assert_errs = u_mini_mcu_top.u_pwr_manager_fsm.u_mini_mcu_assert.fail_cnt;
    $display("Run complete: %0d check errors, %0d assertion failures", err_cnt, assert_errs);
    if (err_cnt == 0 && assert_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
mcu_pkg.sv
rv_timer_lite.sv
irq_collector.sv
pwr_manager_fsm.sv
mini_mcu_top.sv
tb_clk_gen.sv
mini_mcu_assert.sv
tb_mini_mcu.sv
